/* intc_top.f */
logic/intc_bus_pkg.sv
logic/intc_cfg_pkg.sv
logic/pi_slave_port.sv
logic/intc_cmd_decode.sv
logic/intc_dispatch.sv
logic/intc_top.sv
test/intc_dest_model.sv
test/intc_tb.sv

/* test/intc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module intc_tb;

	import intc_bus_pkg::*;
	import intc_cfg_pkg::*;

	logic                    clk;
	logic                    rst;
	pi_req_t                 pi_req;
	pi_rsp_t                 pi_rsp;
	logic [dst_count-1:0]    intrqst_dst;
	logic [dst_count-1:0]    intrdy_dst;
	logic [dst_count-1:0]    intbest_dst;
	logic [src_count-1:0]    intrqst_src;
	logic [src_count-1:0]    intrdy_src;

	// stimulus for the source and destination model
	logic [src_count-1:0]    src_want;
	logic [dst_count-1:0]    dst_rdy_m;
	logic [dst_count-1:0]    dst_best_m;

	// reference state updated by commands and by observed dispatches
	logic [src_count-1:0]    src_en;
	logic [dst_count-1:0]    dst_en;
	logic                    pend;
	logic                    directed;
	int                      target;
	int                      cur_dst;
	int                      cur_src;
	int                      disp_count;

	logic [data_w-1:0]       exp_q[$];
	logic                    rdy_prev = 1'b1;
	logic [dst_count-1:0]    rq_prev;
	int                      errors;
	int                      checks;
	integer                  seed;

	intc_top i_intc_top (
		.clk_i         (clk),
		.rst_i         (rst),
		.pi_req_i      (pi_req),
		.pi_rsp_o      (pi_rsp),
		.intrqst_dst_o (intrqst_dst),
		.intrdy_dst_i  (intrdy_dst),
		.intbest_dst_i (intbest_dst),
		.intrqst_src_i (intrqst_src),
		.intrdy_src_o  (intrdy_src)
	);

	intc_dest_model i_intc_dest_model (
		.clk_i         (clk),
		.src_want_i    (src_want),
		.intrdy_src_i  (intrdy_src),
		.intrqst_src_o (intrqst_src),
		.dst_rdy_i     (dst_rdy_m),
		.dst_best_i    (dst_best_m),
		.intrdy_dst_o  (intrdy_dst),
		.intbest_dst_o (intbest_dst)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_eq(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
			input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	// command word builders with the kind in bits 1:0
	function automatic logic [data_w-1:0] ena_word(input int idx, input logic en);
		return {idx[12:0], en, 2'b10};
	endfunction

	function automatic logic [data_w-1:0] ack_word(input int idx, input logic en);
		return {idx[12:0], en, 2'b00};
	endfunction

	function automatic logic [data_w-1:0] dst_word(input int idx);
		return {idx[13:0], 2'b01};
	endfunction

	// expected bus result of one command
	// the command's effect goes into the reference state
	function automatic logic [data_w-1:0] expect_result(input logic [data_w-1:0] word);
		logic [13:0]          idx;
		logic [data_w-1:0]    res;
		res = res_invalid;
		case (word[1:0])
			2'b10: begin
				idx = {1'b0, word[15:3]};
				if (idx < src_count) begin
					res = {2'b00, idx};
					src_en[idx[1:0]] = word[2];
				end
			end
			2'b01: begin
				idx = word[15:2];
				if (idx < dst_count) begin
					if (pend) begin
						res = res_busy;
					end else begin
						res = {2'b00, idx};
						pend = 1'b1;
						directed = 1'b1;
						target = idx;
					end
				end
			end
			2'b00: begin
				idx = {1'b0, word[15:3]};
				if (pend && (idx == cur_dst)) begin
					// directed interrupts have no source to report
					res = directed ? res_invalid : cur_src[data_w-1:0];
					pend = 1'b0;
					directed = 1'b0;
				end else begin
					res = res_busy;
				end
				// every acknowledge with a valid index writes the destination enable
				if (idx < dst_count) begin
					dst_en[idx[1:0]] = word[2];
				end
			end
			default: begin
				res = res_invalid;
			end
		endcase
		return res;
	endfunction

	// lowest enabled destination that is best or that is ready while none is best
	function automatic int choose_dest();
		logic any_best;
		any_best = |(dst_best_m & dst_en);
		for (int d = 0; d < dst_count; d++) begin
			if (dst_en[d] && (dst_best_m[d] || (dst_rdy_m[d] && !any_best))) begin
				return d;
			end
		end
		return -1;
	endfunction

	// next requesting enabled source cyclically after last
	function automatic int next_served(input int last, input logic [src_count-1:0] live);
		int s;
		for (int k = 1; k <= src_count; k++) begin
			s = (last + k) % src_count;
			if (live[s]) begin
				return s;
			end
		end
		return -1;
	endfunction

	// one read-write op with its expected result queued for the compare process
	task automatic run_cmd(input logic [data_w-1:0] word);
		int n;
		exp_q.push_back(expect_result(word));
		pi_req.op   = pi_rwop;
		pi_req.data = word;
		// rdy is high here, so the next edge accepts
		@(posedge clk);
		#2;
		pi_req.op = pi_noop;
		n = 0;
		while (!pi_rsp.rdy && n < 20) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!pi_rsp.rdy) begin
			errors++;
			$display("ERROR: bus rdy did not return after a command at t=%0t", $time);
		end
	endtask

	task automatic wait_dispatch(input int n0);
		int n;
		n = 0;
		while (disp_count == n0 && n < 100) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (disp_count == n0) begin
			errors++;
			$display("ERROR: no interrupt was dispatched within 100 cycles at t=%0t", $time);
		end
	endtask

	// called on a rising intrqst_dst bit
	task automatic note_dispatch();
		int hits;
		hits = 0;
		for (int d = 0; d < dst_count; d++) begin
			if (intrqst_dst[d]) begin
				cur_dst = d;
				hits++;
			end
		end
		check_eq(hits, 1, "one destination sees intrqst");
		if (directed) begin
			check_eq(cur_dst, target, "directed interrupt destination");
			check_eq(intrdy_src, {src_count{1'b1}}, "no source held by directed interrupt");
		end else begin
			hits = 0;
			for (int s = 0; s < src_count; s++) begin
				if (!intrdy_src[s]) begin
					cur_src = s;
					hits++;
				end
			end
			check_eq(hits, 1, "one source held low");
			check_eq(src_en[cur_src], 1'b1, "dispatched source is enabled");
			check_eq(cur_dst, choose_dest(), "destination choice");
		end
		pend = 1'b1;
		disp_count++;
	endtask

	// bus results compared when rdy rises
	always @(negedge clk) begin
		if (!rst && pi_rsp.rdy === 1'b1 && rdy_prev === 1'b0) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR: bus answered with no command outstanding at t=%0t", $time);
			end else begin
				check_eq(pi_rsp.data, exp_q.pop_front(), "bus result");
			end
		end
		rdy_prev = pi_rsp.rdy;
	end

	// dispatch monitor
	always @(negedge clk) begin
		if (rst) begin
			rq_prev = '0;
		end else begin
			if ((intrqst_dst & ~rq_prev) != '0) begin
				note_dispatch();
			end
			rq_prev = intrqst_dst;
		end
	end

	// six tests of 400 cycles each on a 20 ns clock
	initial begin
		#(6 * 400 * 20);
		$display("ERROR: watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	task automatic enable_masks();
		int n0;
		n0 = disp_count;
		src_want  = '1;
		dst_rdy_m = '1;
		// with every destination enabled and ready only the source mask holds requests back
		for (int d = 0; d < dst_count; d++) begin
			run_cmd(ack_word(d, 1'b1));
		end
		for (int i = 0; i < 6; i++) begin
			run_cmd(ena_word(i, 1'b0));
		end
		// index 100 has low bits 00 and must not reach source 0
		run_cmd(ena_word(100, 1'b1));
		// kind 2'b11 is unknown
		run_cmd(16'h0013);
		// long enough for the scan to visit every source
		repeat (2 * src_count) @(posedge clk);
		#2;
		check_eq(disp_count, n0, "no dispatch while sources disabled");
		src_want = '0;
	endtask

	task automatic first_dispatch();
		int n0;
		for (int d = 0; d < dst_count; d++) begin
			run_cmd(ack_word(d, 1'b1));
		end
		dst_rdy_m  = '1;
		dst_best_m = '0;
		run_cmd(ena_word(2, 1'b1));
		n0 = disp_count;
		src_want = 4'b0100;
		wait_dispatch(n0);
		check_eq(cur_dst, 0, "lowest ready destination");
		check_eq(cur_src, 2, "requesting source dispatched");
		check_eq(intrdy_src[2], 1'b0, "source intrdy low while pending");
		src_want = '0;
		run_cmd(ack_word(cur_dst, 1'b1));
		check_eq(intrdy_src, {src_count{1'b1}}, "intrdy restored after acknowledge");
	endtask

	task automatic wrong_ack();
		int n0;
		n0 = disp_count;
		src_want = 4'b0100;
		wait_dispatch(n0);
		src_want = '0;
		run_cmd(ack_word(1, 1'b1));
		check_eq(intrqst_dst, 3'b001, "interrupt still pending after wrong acknowledge");
		check_eq(intrdy_src[2], 1'b0, "source still held after wrong acknowledge");
		run_cmd(ack_word(0, 1'b1));
	endtask

	task automatic directed_irq();
		int n0;
		n0 = disp_count;
		run_cmd(dst_word(2));
		wait_dispatch(n0);
		check_eq(intrqst_dst, 3'b100, "directed intrqst only at target");
		run_cmd(dst_word(1));
		check_eq(intrdy_src, {src_count{1'b1}}, "sources untouched by directed interrupt");
		run_cmd(ack_word(2, 1'b1));
		run_cmd(dst_word(3));
		run_cmd(dst_word(9));
	endtask

	task automatic best_preferred();
		int n0;
		dst_rdy_m  = 3'b011;
		dst_best_m = 3'b100;
		run_cmd(ena_word(1, 1'b1));
		n0 = disp_count;
		src_want = 4'b0010;
		wait_dispatch(n0);
		check_eq(cur_dst, 2, "best destination preferred");
		check_eq(cur_src, 1, "source 1 dispatched");
		src_want = '0;
		run_cmd(ack_word(cur_dst, 1'b1));
		dst_rdy_m  = '1;
		dst_best_m = '0;
	endtask

	task automatic random_rr();
		logic [src_count-1:0]    want_r;
		logic [src_count-1:0]    en_r;
		logic [src_count-1:0]    live;
		int                      last;
		int                      n0;
		for (int cfg = 0; cfg < 2; cfg++) begin
			want_r = $random(seed);
			en_r   = $random(seed);
			if ((want_r & en_r) == '0) begin
				want_r[0] = 1'b1;
				en_r[0]   = 1'b1;
			end
			live = want_r & en_r;
			for (int s = 0; s < src_count; s++) begin
				run_cmd(ena_word(s, en_r[s]));
			end
			last = -1;
			n0 = disp_count;
			src_want = want_r;
			for (int r = 0; r < 8; r++) begin
				wait_dispatch(n0);
				check_eq(live[cur_src], 1'b1, "served source enabled and requesting");
				// scan start is arbitrary until the first acknowledge
				if (last >= 0) begin
					check_eq(cur_src, next_served(last, live), "round-robin order");
				end
				last = cur_src;
				if (r == 7) begin
					src_want = '0;
				end
				n0 = disp_count;
				run_cmd(ack_word(cur_dst, 1'b1));
			end
			repeat (6) @(posedge clk);
			#2;
			check_eq(intrqst_dst, '0, "nothing pending once requests stop");
		end
	endtask

	initial begin
		seed        = 27430;
		errors      = 0;
		checks      = 0;
		disp_count  = 0;
		src_en      = '0;
		dst_en      = '0;
		pend        = 1'b0;
		directed    = 1'b0;
		target      = 0;
		cur_dst     = 0;
		cur_src     = 0;
		pi_req.op   = pi_noop;
		pi_req.data = '0;
		src_want    = '0;
		dst_rdy_m   = '0;
		dst_best_m  = '0;
		rst         = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		check_eq(pi_rsp.rdy, 1'b1, "rdy high after reset");
		check_eq(intrqst_dst, '0, "no intrqst after reset");
		check_eq(intrdy_src, {src_count{1'b1}}, "all intrdy high after reset");

		enable_masks();
		first_dispatch();
		wrong_ack();
		directed_irq();
		best_preferred();
		random_rr();

		repeat (4) @(posedge clk);
		if (exp_q.size() != 0) begin
			errors++;
			$display("ERROR: %0d bus results never arrived", exp_q.size());
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/intc_dest_model.sv */
`timescale 1ns/1ps
`default_nettype none

module intc_dest_model (
	input  logic                                  clk_i,
	input  logic [intc_cfg_pkg::src_count-1:0]    src_want_i,
	input  logic [intc_cfg_pkg::src_count-1:0]    intrdy_src_i,
	output logic [intc_cfg_pkg::src_count-1:0]    intrqst_src_o,
	input  logic [intc_cfg_pkg::dst_count-1:0]    dst_rdy_i,
	input  logic [intc_cfg_pkg::dst_count-1:0]    dst_best_i,
	output logic [intc_cfg_pkg::dst_count-1:0]    intrdy_dst_o,
	output logic [intc_cfg_pkg::dst_count-1:0]    intbest_dst_o
);

	import intc_cfg_pkg::*;

	// values seen 1 ns after the edge, applied 1 ns later
	logic [src_count-1:0]    want_s;
	logic [src_count-1:0]    src_rdy_s;
	logic [dst_count-1:0]    dst_rdy_s;
	logic [dst_count-1:0]    dst_best_s;

	// all lines quiet before the first edge
	logic [src_count-1:0]    req_q  = '0;
	logic [dst_count-1:0]    rdy_q  = '0;
	logic [dst_count-1:0]    best_q = '0;

	always @(posedge clk_i) begin
		#1;
		want_s     = src_want_i;
		src_rdy_s  = intrdy_src_i;
		dst_rdy_s  = dst_rdy_i;
		dst_best_s = dst_best_i;
		#1;
		// a source requests while it wants service and is not being served,
		// so intrqst drops right after its intrdy falls
		req_q  = want_s & src_rdy_s;
		rdy_q  = dst_rdy_s;
		best_q = dst_best_s;
	end

	assign intrqst_src_o = req_q;
	assign intrdy_dst_o  = rdy_q;
	assign intbest_dst_o = best_q;

endmodule

`default_nettype wire

/* logic/intc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module intc_top (
	input  logic                                    clk_i,
	input  logic                                    rst_i,
	input  intc_bus_pkg::pi_req_t                   pi_req_i,
	output intc_bus_pkg::pi_rsp_t                   pi_rsp_o,
	output logic [intc_cfg_pkg::dst_count-1:0]      intrqst_dst_o,
	input  logic [intc_cfg_pkg::dst_count-1:0]      intrdy_dst_i,
	input  logic [intc_cfg_pkg::dst_count-1:0]      intbest_dst_i,
	input  logic [intc_cfg_pkg::src_count-1:0]      intrqst_src_i,
	output logic [intc_cfg_pkg::src_count-1:0]      intrdy_src_o
);

	import intc_bus_pkg::*;
	import intc_cfg_pkg::*;

	// port to decoder
	logic [data_w-1:0]   cmd_word;
	logic                cmd_stb;

	// decoder to dispatcher
	intc_cmd_t           cmd;

	// dispatcher back to port
	logic [data_w-1:0]   result;
	logic                result_stb;

	// bus side, owns rdy timing
	pi_slave_port i_pi_slave_port (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.pi_req_i     (pi_req_i),
		.pi_rsp_o     (pi_rsp_o),
		.cmd_word_o   (cmd_word),
		.cmd_stb_o    (cmd_stb),
		.result_i     (result),
		.result_stb_i (result_stb)
	);

	// one register stage between port and dispatcher
	intc_cmd_decode i_intc_cmd_decode (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cmd_word_i (cmd_word),
		.cmd_stb_i  (cmd_stb),
		.cmd_o      (cmd)
	);

	intc_dispatch i_intc_dispatch (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.cmd_i         (cmd),
		.result_o      (result),
		.result_stb_o  (result_stb),
		.intrqst_dst_o (intrqst_dst_o),
		.intrdy_dst_i  (intrdy_dst_i),
		.intbest_dst_i (intbest_dst_i),
		.intrqst_src_i (intrqst_src_i),
		.intrdy_src_o  (intrdy_src_o)
	);

endmodule

`default_nettype wire

/* logic/intc_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module intc_dispatch (
	input  logic                                    clk_i,
	input  logic                                    rst_i,
	input  intc_cfg_pkg::intc_cmd_t                 cmd_i,
	output logic [intc_bus_pkg::data_w-1:0]         result_o,
	output logic                                    result_stb_o,
	output logic [intc_cfg_pkg::dst_count-1:0]      intrqst_dst_o,
	input  logic [intc_cfg_pkg::dst_count-1:0]      intrdy_dst_i,
	input  logic [intc_cfg_pkg::dst_count-1:0]      intbest_dst_i,
	input  logic [intc_cfg_pkg::src_count-1:0]      intrqst_src_i,
	output logic [intc_cfg_pkg::src_count-1:0]      intrdy_src_o
);

	import intc_bus_pkg::*;
	import intc_cfg_pkg::*;

	// enable masks, both clear out of reset
	logic [src_count-1:0]    src_en_q;
	logic [dst_count-1:0]    dst_en_q;

	// round-robin scan position
	logic [src_idx_w-1:0]    src_idx_q;
	logic [dst_idx_w-1:0]    dst_idx_q;

	// one interrupt outstanding at a time
	logic                    pending_q;

	// set by a directed command, cleared with its acknowledge
	logic                    directed_q;
	logic [dst_idx_w-1:0]    target_q;

	logic [src_idx_w-1:0]    next_src;
	logic [dst_idx_w-1:0]    next_dst;
	logic                    seeking;
	logic                    is_ena;
	logic                    is_dst;
	logic                    is_ack;
	logic                    ack_ok;
	logic                    any_best;
	logic                    offer_ok;
	logic [src_idx_w-1:0]    cmd_src;
	logic [dst_idx_w-1:0]    cmd_dst;

	// wrap at the count, not at the power of two
	assign next_src = (src_idx_q == src_idx_w'(src_count - 1)) ? '0 : src_idx_q + 1'b1;
	assign next_dst = (dst_idx_q == dst_idx_w'(dst_count - 1)) ? '0 : dst_idx_q + 1'b1;

	// directed interrupt still walking dst_idx toward its target
	assign seeking = directed_q && (dst_idx_q != target_q);

	assign is_ena = cmd_i.valid && (cmd_i.kind == cmd_enaint);
	assign is_dst = cmd_i.valid && (cmd_i.kind == cmd_intdst);
	assign is_ack = cmd_i.valid && (cmd_i.kind == cmd_ackint);

	// only meaningful when in_range is set
	assign cmd_src = cmd_i.idx[src_idx_w-1:0];
	assign cmd_dst = cmd_i.idx[dst_idx_w-1:0];

	// acknowledge must name the destination that sees intrqst
	// full index compared so an out of range index never matches
	assign ack_ok = is_ack && pending_q && !seeking &&
		(cmd_i.idx == {{(idx_w-dst_idx_w){1'b0}}, dst_idx_q});

	// a halted destination wins over a merely ready one
	assign any_best = |(intbest_dst_i & dst_en_q);
	assign offer_ok = dst_en_q[dst_idx_q] &&
		(intbest_dst_i[dst_idx_q] || (intrdy_dst_i[dst_idx_q] && !any_best));

	// every command is answered in the cycle it executes
	assign result_stb_o = cmd_i.valid;

	always_comb begin
		result_o = res_invalid;
		if (is_ena) begin
			if (cmd_i.in_range) begin
				result_o = {{(data_w-src_idx_w){1'b0}}, cmd_src};
			end
		end else if (is_dst) begin
			// range is checked before pending
			if (cmd_i.in_range) begin
				if (pending_q) begin
					result_o = res_busy;
				end else begin
					result_o = {{(data_w-dst_idx_w){1'b0}}, cmd_dst};
				end
			end
		end else if (is_ack) begin
			if (!ack_ok) begin
				result_o = res_busy;
			end else if (!directed_q) begin
				result_o = {{(data_w-src_idx_w){1'b0}}, src_idx_q};
			end
			// a directed interrupt has no source, keeps res_invalid
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			src_en_q   <= '0;
			dst_en_q   <= '0;
			src_idx_q  <= '0;
			dst_idx_q  <= '0;
			pending_q  <= 1'b0;
			directed_q <= 1'b0;
			target_q   <= '0;
		end else begin
			if (is_ena) begin
				if (cmd_i.in_range) begin
					src_en_q[cmd_src] <= cmd_i.en;
				end
			end else if (is_dst) begin
				// refused while another interrupt is outstanding
				if (cmd_i.in_range && !pending_q) begin
					pending_q  <= 1'b1;
					directed_q <= 1'b1;
					target_q   <= cmd_dst;
				end
			end else if (seeking) begin
				dst_idx_q <= next_dst;
			end else if (pending_q || is_ack) begin
				// scan holds while pending
				if (ack_ok) begin
					pending_q  <= 1'b0;
					directed_q <= 1'b0;
					// lowest destination first on the next dispatch
					dst_idx_q  <= '0;
					src_idx_q  <= next_src;
				end
			end else if (src_en_q[src_idx_q] && intrqst_src_i[src_idx_q]) begin
				// keep the source, walk destinations until one takes it
				if (offer_ok) begin
					pending_q <= 1'b1;
				end else begin
					dst_idx_q <= next_dst;
				end
			end else begin
				src_idx_q <= next_src;
			end

			// any acknowledge with a valid index also sets that destination's enable,
			// whatever its result
			if (is_ack && cmd_i.in_range) begin
				dst_en_q[cmd_dst] <= cmd_i.en;
			end
		end
	end

	// request only at the indexed destination, and not while seeking
	always_comb begin
		for (int d = 0; d < dst_count; d++) begin
			intrqst_dst_o[d] = pending_q && !seeking && (dst_idx_q == dst_idx_w'(d));
		end
	end

	// intrdy low at the dispatched source until it is acknowledged
	// directed interrupts leave every source untouched
	always_comb begin
		for (int s = 0; s < src_count; s++) begin
			intrdy_src_o[s] = !(pending_q && !directed_q && (src_idx_q == src_idx_w'(s)));
		end
	end

endmodule

`default_nettype wire

/* logic/intc_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module intc_cmd_decode (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic [intc_bus_pkg::data_w-1:0]     cmd_word_i,
	input  logic                                cmd_stb_i,
	output intc_cfg_pkg::intc_cmd_t             cmd_o
);

	import intc_bus_pkg::*;
	import intc_cfg_pkg::*;

	cmd_t                kind_d;
	logic [idx_w-1:0]    idx_d;
	logic                in_range_d;

	logic                valid_q;
	cmd_t                kind_q;
	logic [idx_w-1:0]    idx_q;
	logic                en_q;
	logic                in_range_q;

	always_comb begin
		// kind sits in bits 1:0, 2'b11 passes through as an unknown kind
		kind_d = cmd_t'(cmd_word_i[1:0]);
		// directed interrupt has no enable bit, its index starts at bit 2
		if (kind_d == cmd_intdst) begin
			idx_d = cmd_word_i[data_w-1:2];
		end else begin
			idx_d = {1'b0, cmd_word_i[data_w-1:3]};
		end
		// range test done once here
		case (kind_d)
			cmd_enaint: begin
				in_range_d = (idx_d < src_count);
			end
			cmd_ackint, cmd_intdst: begin
				in_range_d = (idx_d < dst_count);
			end
			default: begin
				in_range_d = 1'b0;
			end
		endcase
	end

	// valid follows the strobe one cycle later
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= cmd_stb_i;
		end
	end

	// fields only change with a new command
	always_ff @(posedge clk_i) begin
		if (cmd_stb_i) begin
			kind_q     <= kind_d;
			idx_q      <= idx_d;
			en_q       <= cmd_word_i[2];
			in_range_q <= in_range_d;
		end
	end

	assign cmd_o = '{
		valid:    valid_q,
		kind:     kind_q,
		idx:      idx_q,
		en:       en_q,
		in_range: in_range_q
	};

endmodule

`default_nettype wire

/* logic/pi_slave_port.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_slave_port (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  intc_bus_pkg::pi_req_t               pi_req_i,
	output intc_bus_pkg::pi_rsp_t               pi_rsp_o,
	output logic [intc_bus_pkg::data_w-1:0]     cmd_word_o,
	output logic                                cmd_stb_o,
	input  logic [intc_bus_pkg::data_w-1:0]     result_i,
	input  logic                                result_stb_i
);

	import intc_bus_pkg::*;

	// idle takes a request, issued strobes it to the core,
	// wait holds rdy low until the core answers
	typedef enum logic [1:0] {
		st_idle,
		st_issued,
		st_wait
	} state_t;

	state_t              state_q;
	logic [data_w-1:0]   cmd_word_q;
	logic [data_w-1:0]   rsp_data_q;
	logic                accept;

	// only a read-write op goes to the core
	// other ops leave rdy high and see the previous data
	assign accept = (state_q == st_idle) && (pi_req_i.op == pi_rwop);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: begin
					if (accept) begin
						state_q <= st_issued;
					end
				end
				// strobe lasts exactly one cycle
				st_issued: begin
					state_q <= st_wait;
				end
				st_wait: begin
					if (result_stb_i) begin
						state_q <= st_idle;
					end
				end
				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// command word captured at the accept edge
	// result held until the next accepted request
	always_ff @(posedge clk_i) begin
		if (accept) begin
			cmd_word_q <= pi_req_i.data;
		end
		if ((state_q == st_wait) && result_stb_i) begin
			rsp_data_q <= result_i;
		end
	end

	assign cmd_word_o = cmd_word_q;
	assign cmd_stb_o  = (state_q == st_issued);

	// rdy low while a command is in flight
	assign pi_rsp_o = '{data: rsp_data_q, rdy: (state_q == st_idle)};

endmodule

`default_nettype wire

/* logic/intc_cfg_pkg.sv */
`default_nettype none

package intc_cfg_pkg;

	// interrupt sources and destinations in this system
	localparam int src_count = 4;
	localparam int dst_count = 3;

	// index widths, wide enough for count-1
	localparam int src_idx_w = 2;
	localparam int dst_idx_w = 2;

	// widest index field in a command word, the one of cmd_intdst
	localparam int idx_w = intc_bus_pkg::data_w - 2;

	// command kind in the low two bits of the command word
	// 2'b11 is unused and answered as invalid
	typedef enum logic [1:0] {
		cmd_ackint = 2'b00,
		cmd_intdst = 2'b01,
		cmd_enaint = 2'b10
	} cmd_t;

	// all ones, bad index or unknown command
	// also returned when acknowledging a directed interrupt
	localparam logic [intc_bus_pkg::data_w-1:0] res_invalid = '1;

	// all ones but bit 0, not ready or nothing pending at that destination
	localparam logic [intc_bus_pkg::data_w-1:0] res_busy =
		{{(intc_bus_pkg::data_w-1){1'b1}}, 1'b0};

	// command after decode, one cycle wide
	// idx is zero extended from bit 3 up, or taken from bit 2 up for cmd_intdst
	// in_range is against src_count for cmd_enaint, else against dst_count
	typedef struct packed {
		logic                valid;
		cmd_t                kind;
		logic [idx_w-1:0]    idx;
		logic                en;
		logic                in_range;
	} intc_cmd_t;

endpackage

`default_nettype wire

/* logic/intc_bus_pkg.sv */
`default_nettype none

package intc_bus_pkg;

	// width of the PerInt data path in both directions
	localparam int data_w = 16;

	// PerInt operation codes as seen on the op lines
	typedef enum logic [1:0] {
		pi_noop = 2'b00,
		pi_wrop = 2'b01,
		pi_rdop = 2'b10,
		pi_rwop = 2'b11
	} pi_op_t;

	// master to slave
	// address and byte selects are not carried, the controller decodes neither
	typedef struct packed {
		pi_op_t              op;
		logic [data_w-1:0]   data;
	} pi_req_t;

	// slave to master
	// rdy high means the slave takes a new op and data holds the last result
	typedef struct packed {
		logic [data_w-1:0]   data;
		logic                rdy;
	} pi_rsp_t;

endpackage

`default_nettype wire
